// ==== logic/fft_pkg.sv ====
package fft_pkg;

    // ------------------------------
    // Transform size
    // ------------------------------
    localparam int FFT_N       = 16;                // Points per frame
    localparam int LOG_N       = $clog2(FFT_N);     // Address bits of one frame
    localparam int FFT_LATENCY = 21;                // Input strobe to output strobe

    // ------------------------------
    // Datapath widths
    // ------------------------------
    localparam int DATA_W  = 16;                    // Real or imaginary part
    localparam int TW_FRAC = 14;                    // Twiddle fraction bits

    typedef logic signed [DATA_W-1:0] sample_t;     // One part of a complex sample
    typedef logic signed [15:0]       twiddle_t;    // Coefficient in Q2.14
    typedef logic [LOG_N-1:0]         index_t;      // Position within a frame

    // ------------------------------
    // Helpers
    // ------------------------------

    // Output bins leave in this order
    function automatic index_t bit_reverse(input index_t idx);
        index_t rev;
        for (int i = 0; i < LOG_N; i++) begin
            rev[i] = idx[LOG_N-1-i];                // Mirror bit positions
        end
        return rev;
    endfunction

endpackage

// ==== logic/sdf_butterfly.sv ====
`timescale 1ns/10ps

module sdf_butterfly #(
    parameter int DEPTH = 8                                 // Feedback line, half a block
) (
    input  logic             clock,
    input  logic             rst_i,
    input  logic             di_en_i,                       // Input sample strobe
    input  logic             rot_i,                         // Multiply input by -j
    input  fft_pkg::sample_t di_re_i,
    input  fft_pkg::sample_t di_im_i,
    output logic             do_en_o,                       // Output sample strobe
    output fft_pkg::sample_t do_re_o,
    output fft_pkg::sample_t do_im_o
);

    localparam int CNT_W = $clog2(2 * DEPTH);               // Counts one block of 2*DEPTH

    logic [CNT_W-1:0]                cnt;                   // Input position in block
    logic                            second_half;           // Butterfly half
    logic [DEPTH:0]                  en_sr;                 // Strobe delay incl. output reg
    fft_pkg::sample_t                in_re;                 // Input after rotation
    fft_pkg::sample_t                in_im;
    fft_pkg::sample_t                line_re [DEPTH];       // Feedback delay line
    fft_pkg::sample_t                line_im [DEPTH];
    fft_pkg::sample_t                head_re;               // Oldest entry of the line
    fft_pkg::sample_t                head_im;
    logic signed [fft_pkg::DATA_W:0] sum_re;                // Full width butterfly results
    logic signed [fft_pkg::DATA_W:0] sum_im;
    logic signed [fft_pkg::DATA_W:0] dif_re;
    logic signed [fft_pkg::DATA_W:0] dif_im;
    fft_pkg::sample_t                bf_re;                 // Next output value
    fft_pkg::sample_t                bf_im;
    fft_pkg::sample_t                fb_re;                 // Next line entry
    fft_pkg::sample_t                fb_im;

    // ------------------------------
    // Block position
    // ------------------------------
    always_ff @(posedge clock) begin
        if (rst_i) begin
            cnt <= '0;
        end else if (di_en_i) begin
            cnt <= cnt + 1'b1;                              // Wraps at 2*DEPTH
        end else begin
            cnt <= '0;                                      // Idle, line drains
        end
    end

    assign second_half = cnt[CNT_W-1];

    // (a + jb) * -j = b - ja
    assign in_re = rot_i ? di_im_i : di_re_i;
    assign in_im = rot_i ? -di_re_i : di_im_i;

    // ------------------------------
    // Butterfly and feedback
    // ------------------------------
    assign head_re = line_re[DEPTH-1];
    assign head_im = line_im[DEPTH-1];
    assign sum_re  = head_re + in_re;                       // Earlier sample plus current
    assign sum_im  = head_im + in_im;
    assign dif_re  = head_re - in_re;                       // Earlier sample minus current
    assign dif_im  = head_im - in_im;

    // First half stores input and sends out old differences
    assign bf_re = second_half ? sum_re[fft_pkg::DATA_W:1] : head_re;
    assign bf_im = second_half ? sum_im[fft_pkg::DATA_W:1] : head_im;
    assign fb_re = second_half ? dif_re[fft_pkg::DATA_W:1] : in_re;
    assign fb_im = second_half ? dif_im[fft_pkg::DATA_W:1] : in_im;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                line_re[i] <= '0;
                line_im[i] <= '0;
            end
        end else begin
            line_re[0] <= fb_re;                            // Shifts every cycle
            line_im[0] <= fb_im;
            for (int i = 1; i < DEPTH; i++) begin
                line_re[i] <= line_re[i-1];
                line_im[i] <= line_im[i-1];
            end
        end
    end

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clock) begin
        if (rst_i) begin
            en_sr   <= '0;
            do_re_o <= '0;
            do_im_o <= '0;
        end else begin
            en_sr   <= {en_sr[DEPTH-1:0], di_en_i};         // DEPTH plus 1 cycles
            do_re_o <= bf_re;
            do_im_o <= bf_im;
        end
    end

    assign do_en_o = en_sr[DEPTH];

endmodule

// ==== logic/twiddle_mult.sv ====
`timescale 1ns/10ps

module twiddle_mult (
    input  logic             clock,
    input  logic             rst_i,
    input  logic             di_en_i,                       // Input sample strobe
    input  fft_pkg::index_t  pos_i,                         // Sample position p in block
    input  fft_pkg::sample_t di_re_i,
    input  fft_pkg::sample_t di_im_i,
    output logic             do_en_o,                       // Output sample strobe
    output fft_pkg::sample_t do_re_o,
    output fft_pkg::sample_t do_im_o
);

    localparam int PROD_W = fft_pkg::DATA_W + $bits(fft_pkg::twiddle_t) + 1;
    localparam logic signed [PROD_W-1:0] ROUND = PROD_W'(2 ** (fft_pkg::TW_FRAC - 1));

    // ------------------------------
    // Twiddle table, k = 0 to 15
    // ------------------------------
    // cos(2*pi*k/16)
    localparam fft_pkg::twiddle_t COS_TAB [16] = '{
         16384,  15137,  11585,   6270,      0,  -6270, -11585, -15137,
        -16384, -15137, -11585,  -6270,      0,   6270,  11585,  15137
    };
    // -sin(2*pi*k/16)
    localparam fft_pkg::twiddle_t NSIN_TAB [16] = '{
             0,  -6270, -11585, -15137, -16384, -15137, -11585,  -6270,
             0,   6270,  11585,  15137,  16384,  15137,  11585,   6270
    };

    logic [1:0]               col;                          // p mod 4
    logic [1:0]               row;                          // Factor picked by p / 4
    fft_pkg::index_t          tw_exp;                       // Twiddle exponent, at most 9
    fft_pkg::twiddle_t        tw_re;
    fft_pkg::twiddle_t        tw_im;
    logic signed [PROD_W-1:0] prod_re;                      // Rounded full width product
    logic signed [PROD_W-1:0] prod_im;

    // ------------------------------
    // Exponent selection
    // ------------------------------
    assign col = pos_i[1:0];

    // Quarter order of the stage output is 0, 2, 1, 3
    always_comb begin
        case (pos_i[3:2])
            2'd0:    row = 2'd0;
            2'd1:    row = 2'd2;
            2'd2:    row = 2'd1;
            default: row = 2'd3;
        endcase
    end

    assign tw_exp = col * row;                              // 4 bit product
    assign tw_re  = COS_TAB[tw_exp];
    assign tw_im  = NSIN_TAB[tw_exp];

    // ------------------------------
    // Complex product
    // ------------------------------
    // (a + jb)(c + jd) = (ac - bd) + j(ad + bc)
    assign prod_re = di_re_i * tw_re - di_im_i * tw_im + ROUND;
    assign prod_im = di_re_i * tw_im + di_im_i * tw_re + ROUND;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            do_en_o <= 1'b0;
            do_re_o <= '0;
            do_im_o <= '0;
        end else begin
            do_en_o <= di_en_i;                             // One cycle latency
            do_re_o <= prod_re[fft_pkg::TW_FRAC +: fft_pkg::DATA_W];  // Drop Q2.14 scale
            do_im_o <= prod_im[fft_pkg::TW_FRAC +: fft_pkg::DATA_W];
        end
    end

endmodule

// ==== logic/sdf_unit.sv ====
`timescale 1ns/10ps

module sdf_unit #(
    parameter int M = 16                                    // Twiddle resolution
) (
    input  logic             clock,
    input  logic             rst_i,
    input  logic             di_en_i,                       // Input sample strobe
    input  fft_pkg::sample_t di_re_i,
    input  fft_pkg::sample_t di_im_i,
    output logic             do_en_o,                       // Output sample strobe
    output fft_pkg::sample_t do_re_o,
    output fft_pkg::sample_t do_im_o
);

    localparam int CNT_W   = $clog2(M);                     // Position in M block
    localparam int TAP_ROT = M / 2 + 1;                     // First butterfly latency
    localparam int TAP_TW  = TAP_ROT + M / 4 + 1;           // Plus second butterfly
    localparam int SR_LEN  = (M > 4) ? TAP_TW : TAP_ROT;

    logic [CNT_W-1:0] cnt;                                  // Input position
    logic [CNT_W-1:0] cnt_sr [SR_LEN];                      // Position follows the data
    logic             rot;                                  // -j for second butterfly
    logic             bf1_en;
    fft_pkg::sample_t bf1_re;
    fft_pkg::sample_t bf1_im;
    logic             bf2_en;
    fft_pkg::sample_t bf2_re;
    fft_pkg::sample_t bf2_im;

    // ------------------------------
    // Position tracking
    // ------------------------------
    always_ff @(posedge clock) begin
        if (rst_i) begin
            cnt <= '0;
            for (int i = 0; i < SR_LEN; i++) begin
                cnt_sr[i] <= '0;
            end
        end else begin
            cnt       <= di_en_i ? cnt + 1'b1 : '0;         // Wraps at M, 0 when idle
            cnt_sr[0] <= cnt;
            for (int i = 1; i < SR_LEN; i++) begin
                cnt_sr[i] <= cnt_sr[i-1];
            end
        end
    end

    // Quarter 3 of each M block holds the k1 = 1, n2 = 1 terms
    assign rot = (cnt_sr[TAP_ROT-1][CNT_W-1 -: 2] == 2'b11);

    // ------------------------------
    // Butterfly pair
    // ------------------------------
    sdf_butterfly #(.DEPTH(M / 2)) bf1_inst (
        .clock   (clock),
        .rst_i   (rst_i),
        .di_en_i (di_en_i),
        .rot_i   (1'b0),                                    // No rotation in first half
        .di_re_i (di_re_i),
        .di_im_i (di_im_i),
        .do_en_o (bf1_en),
        .do_re_o (bf1_re),
        .do_im_o (bf1_im)
    );

    sdf_butterfly #(.DEPTH(M / 4)) bf2_inst (
        .clock   (clock),
        .rst_i   (rst_i),
        .di_en_i (bf1_en),
        .rot_i   (rot),
        .di_re_i (bf1_re),
        .di_im_i (bf1_im),
        .do_en_o (bf2_en),
        .do_re_o (bf2_re),
        .do_im_o (bf2_im)
    );

    generate
        if (M > 4) begin : g_twiddle
            twiddle_mult twiddle_mult_inst (
                .clock   (clock),
                .rst_i   (rst_i),
                .di_en_i (bf2_en),
                .pos_i   (fft_pkg::index_t'(cnt_sr[TAP_TW-1])),
                .di_re_i (bf2_re),
                .di_im_i (bf2_im),
                .do_en_o (do_en_o),
                .do_re_o (do_re_o),
                .do_im_o (do_im_o)
            );
        end else begin : g_trivial
            assign do_en_o = bf2_en;                        // Twiddles are all 1
            assign do_re_o = bf2_re;
            assign do_im_o = bf2_im;
        end
    endgenerate

endmodule

// ==== logic/fft16_top.sv ====
`timescale 1ns/10ps

module fft16_top #(
    parameter int M_FIRST = 16,                             // Unit with twiddle multiplier
    parameter int M_LAST  = 4                               // Unit with -j only
) (
    input  logic             clock,
    input  logic             rst_i,
    input  logic             di_en_i,                       // One sample per strobe
    input  fft_pkg::sample_t di_re_i,                       // Natural order
    input  fft_pkg::sample_t di_im_i,
    output logic             do_en_o,                       // One bin per strobe
    output fft_pkg::sample_t do_re_o,                       // Bit-reversed order
    output fft_pkg::sample_t do_im_o
);

    logic             su1_en;
    fft_pkg::sample_t su1_re;
    fft_pkg::sample_t su1_im;
    logic             su2_en;
    fft_pkg::sample_t su2_re;
    fft_pkg::sample_t su2_im;

    // ------------------------------
    // SDF chain
    // ------------------------------
    sdf_unit #(.M(M_FIRST)) first_unit_inst (
        .clock   (clock),
        .rst_i   (rst_i),
        .di_en_i (di_en_i),
        .di_re_i (di_re_i),
        .di_im_i (di_im_i),
        .do_en_o (su1_en),                                  // 15 cycles later
        .do_re_o (su1_re),
        .do_im_o (su1_im)
    );

    sdf_unit #(.M(M_LAST)) last_unit_inst (
        .clock   (clock),
        .rst_i   (rst_i),
        .di_en_i (su1_en),
        .di_re_i (su1_re),
        .di_im_i (su1_im),
        .do_en_o (su2_en),                                  // 5 more cycles
        .do_re_o (su2_re),
        .do_im_o (su2_im)
    );

    // Output register
    always_ff @(posedge clock) begin
        if (rst_i) begin
            do_en_o <= 1'b0;
            do_re_o <= '0;
            do_im_o <= '0;
        end else begin
            do_en_o <= su2_en;
            do_re_o <= su2_re;
            do_im_o <= su2_im;
        end
    end

endmodule

// ==== verif/fft_checker.sv ====
`timescale 1ns/10ps

module fft_checker (
    input logic clock,
    input logic rst_i,
    input logic di_en_i,                                    // DUT input strobe
    input logic do_en_o                                     // DUT output strobe
);

    int         fail_cnt = 0;                               // Watched by the testbench
    logic [3:0] run_pos;                                    // Output strobes mod 16
    int         hist_cnt;                                   // Cycles since reset, saturates

    always_ff @(posedge clock) begin
        if (rst_i) begin
            run_pos <= '0;
        end else if (do_en_o) begin
            run_pos <= run_pos + 1'b1;                      // Wraps once per frame
        end
    end

    always_ff @(posedge clock) begin
        if (rst_i) begin
            hist_cnt <= 0;
        end else if (hist_cnt != fft_pkg::FFT_LATENCY) begin
            hist_cnt <= hist_cnt + 1;                       // Stops at the latency
        end
    end

    // ------------------------------
    // Enable timing
    // ------------------------------
    reset_quiet: assert property (@(posedge clock) rst_i |=> !do_en_o)
        else begin
            fail_cnt++;
            $error("Output strobe high during or right after reset");
        end

    // Input history reaches back past reset release only once hist_cnt saturates
    fixed_latency: assert property (@(posedge clock) disable iff (rst_i)
        hist_cnt == fft_pkg::FFT_LATENCY |-> do_en_o == $past(di_en_i, fft_pkg::FFT_LATENCY))
        else begin
            fail_cnt++;
            $error("Output strobe is not the input strobe delayed by the FFT latency");
        end

    // A run of strobes ends only on a frame boundary
    frame_runs: assert property (@(posedge clock) disable iff (rst_i)
        $fell(do_en_o) |-> run_pos == 4'd0)
        else begin
            fail_cnt++;
            $error("Output strobe run is not a whole number of frames");
        end

endmodule

// ==== verif/fft_tb.sv ====
`timescale 1ns/10ps

module fft_tb;

    localparam int  CYCLE_LIMIT = 1200;                     // About 20 frames, gaps, latency
    localparam real PI          = 3.14159265358979;
    localparam real TOL         = 4.0;                      // Allowed error in LSB

    logic             clock;
    logic             rst_i;
    logic             di_en_i;
    fft_pkg::sample_t di_re_i;
    fft_pkg::sample_t di_im_i;
    logic             do_en_o;
    fft_pkg::sample_t do_re_o;
    fft_pkg::sample_t do_im_o;

    int    frame_re [16];                                   // Frame about to be sent
    int    frame_im [16];
    real   exp_re [$];                                      // Expected bins in output order
    real   exp_im [$];
    string exp_name [$];
    string cur_name;
    real   cur_re;
    real   cur_im;
    int    bin_pos = 0;                                     // Output position in frame
    int    cycles  = 0;

    fft16_top #(.M_FIRST(16), .M_LAST(4)) fft16_top_inst (
        .clock   (clock),
        .rst_i   (rst_i),
        .di_en_i (di_en_i),
        .di_re_i (di_re_i),
        .di_im_i (di_im_i),
        .do_en_o (do_en_o),
        .do_re_o (do_re_o),
        .do_im_o (do_im_o)
    );

    bind fft16_top fft_checker checker_inst (
        .clock   (clock),
        .rst_i   (rst_i),
        .di_en_i (di_en_i),
        .do_en_o (do_en_o)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;                         // 100 ns period
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Run stopped");
    endtask

    function automatic bit within_tol(input real expv, input int act);
        return (act - expv <= TOL) && (expv - act <= TOL);
    endfunction

    // DFT of the frame, scaled by 1/16, bins queued in bit-reversed order
    task automatic push_expected(input string name);
        int  k;
        real ang;
        real sr;
        real si;
        for (int m = 0; m < fft_pkg::FFT_N; m++) begin
            k  = fft_pkg::bit_reverse(fft_pkg::index_t'(m));
            sr = 0.0;
            si = 0.0;
            for (int n = 0; n < fft_pkg::FFT_N; n++) begin
                ang = 2.0 * PI * n * k / fft_pkg::FFT_N;
                sr += frame_re[n] * $cos(ang) + frame_im[n] * $sin(ang);
                si += frame_im[n] * $cos(ang) - frame_re[n] * $sin(ang);
            end
            exp_re.push_back(sr / fft_pkg::FFT_N);
            exp_im.push_back(si / fft_pkg::FFT_N);
            exp_name.push_back(name);
        end
    endtask

    // Strobe stays high into the next frame when gap is 0
    task automatic send_frame(input string name, input int gap);
        push_expected(name);
        for (int n = 0; n < fft_pkg::FFT_N; n++) begin
            @(negedge clock);
            di_en_i = 1'b1;
            di_re_i = fft_pkg::sample_t'(frame_re[n]);
            di_im_i = fft_pkg::sample_t'(frame_im[n]);
        end
        repeat (gap) begin
            @(negedge clock);
            di_en_i = 1'b0;
        end
    endtask

    task automatic fill_random();
        for (int n = 0; n < fft_pkg::FFT_N; n++) begin
            frame_re[n] = int'($urandom_range(16000, 0)) - 8000;   // Within +-8000
            frame_im[n] = int'($urandom_range(16000, 0)) - 8000;
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        void'($urandom(32'h30cd_b4f8));                     // Fixed seed
        rst_i   = 1'b1;
        di_en_i = 1'b0;
        di_re_i = '0;
        di_im_i = '0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst_i = 1'b0;
        for (int n = 0; n < fft_pkg::FFT_N; n++) begin
            frame_re[n] = (n == 0) ? 1600 : 0;              // Flat spectrum of 100
            frame_im[n] = 0;
        end
        send_frame("impulse", 3);
        for (int n = 0; n < fft_pkg::FFT_N; n++) begin
            frame_re[n] = 800;                              // All energy in bin 0
            frame_im[n] = 0;
        end
        send_frame("dc", 3);
        for (int n = 0; n < fft_pkg::FFT_N; n++) begin
            frame_re[n] = int'(1000.0 * $cos(2.0 * PI * 5 * n / fft_pkg::FFT_N));
            frame_im[n] = int'(1000.0 * $sin(2.0 * PI * 5 * n / fft_pkg::FFT_N));
        end
        send_frame("tone", 3);                              // Peak at bit_reverse(5)
        repeat (6) begin
            fill_random();
            send_frame("random", 0);                        // Back to back
        end
        repeat (6) begin
            fill_random();
            send_frame("gaps", int'($urandom_range(20, 0)));
        end
        @(negedge clock);
        di_en_i = 1'b0;                                     // Last frame flushes alone
        while (exp_re.size() != 0) begin
            @(negedge clock);
        end
        repeat (40) @(negedge clock);                       // Catch stray strobes
        if (fft16_top_inst.checker_inst.fail_cnt != 0) begin
            $display("Simulation failed");
            $fatal(1, "Checker assertion failed");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

    // ------------------------------
    // Output collection
    // ------------------------------
    always @(negedge clock) begin
        if (!rst_i && do_en_o) begin
            if (exp_re.size() == 0) begin
                abort_run("Output strobe with no frame pending");
            end else begin
                cur_name = exp_name.pop_front();
                cur_re   = exp_re.pop_front();
                cur_im   = exp_im.pop_front();
                assert (within_tol(cur_re, do_re_o))
                    else abort_run($sformatf("ERR %s bin %0d re expected %0.2f actual %0d",
                                             cur_name, bin_pos, cur_re, do_re_o));
                assert (within_tol(cur_im, do_im_o))
                    else abort_run($sformatf("ERR %s bin %0d im expected %0.2f actual %0d",
                                             cur_name, bin_pos, cur_im, do_im_o));
                bin_pos = (bin_pos + 1) % fft_pkg::FFT_N;
            end
        end
    end

    always @(negedge clock) begin
        if (fft16_top_inst.checker_inst.fail_cnt != 0) begin
            abort_run("Enable timing assertion failed");
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run("Timeout, outputs did not arrive within the cycle limit");
        end
    end

endmodule

// ==== list.f ====
logic/fft_pkg.sv
logic/sdf_butterfly.sv
logic/twiddle_mult.sv
logic/sdf_unit.sv
logic/fft16_top.sv
verif/fft_checker.sv
verif/fft_tb.sv
